// ==== Makefile ====
VERILATOR ?= verilator
TOP       := bench_role_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== source/access_generator.sv ====
`timescale 1ns/1ns
`default_nettype none

module access_generator (
    input  wire                            net_clk,
    input  wire                            net_aresetn,
    input  wire                            start,
    input  wire bench_pkg::bench_cmd_t     run_cmd,
    output logic                           read_cmd_valid,
    input  wire                            read_cmd_ready,
    output bench_pkg::mem_cmd_t            read_cmd,
    output logic                           write_cmd_valid,
    input  wire                            write_cmd_ready,
    output bench_pkg::mem_cmd_t            write_cmd,
    output logic                           write_data_valid,
    input  wire                            write_data_ready,
    output logic [bench_pkg::DATA_W-1:0]   write_data,
    output logic                           write_data_last,
    input  wire                            read_data_valid,
    output logic                           read_data_ready,
    input  wire [bench_pkg::DATA_W-1:0]    read_data,
    input  wire                            read_data_last,
    input  wire                            write_sts_valid,
    output logic                           write_sts_ready,
    input  wire [bench_pkg::STS_W-1:0]     write_sts,
    output logic                           done,
    output logic [bench_pkg::CYCLE_W-1:0]  cycles
);
    import bench_pkg::*;

    logic               running;
    logic [CNT_W-1:0]   issue_cnt;
    logic [CNT_W-1:0]   done_cnt;
    logic [ADDR_W-1:0]  offset;
    logic [ADDR_W-1:0]  next_offset;
    logic [ADDR_W:0]    next_end;
    logic [ADDR_W-1:0]  acc_addr;
    logic [CYCLE_W-1:0] cycle_cnt;
    logic               beats_active;
    logic [CNT_W-1:0]   beats_left;
    logic [ADDR_W-1:0]  beat_addr;
    logic               sink_ready;
    logic               issue_valid;
    logic               cmd_fire;
    logic               beat_fire;
    logic               complete;
    logic               finish;
    mem_cmd_t           acc_cmd;

    // address walk over the benchmark window
    assign acc_addr = run_cmd.base_addr + offset;
    assign next_offset = offset + ADDR_W'(run_cmd.stride_length);
    assign next_end = {1'b0, next_offset} + (ADDR_W + 1)'(run_cmd.chunk_length);

    always_comb begin
        acc_cmd.length = run_cmd.chunk_length;
        acc_cmd.addr = MEM_ADDR_W'(acc_addr);
    end

    // hold off the next command while write beats are pending
    assign issue_valid = running && !beats_active &&
                         (issue_cnt != run_cmd.number_of_accesses);
    assign read_cmd_valid = issue_valid && !run_cmd.is_write;
    assign write_cmd_valid = issue_valid && run_cmd.is_write;
    assign read_cmd = acc_cmd;
    assign write_cmd = acc_cmd;
    assign cmd_fire = (read_cmd_valid && read_cmd_ready) ||
                      (write_cmd_valid && write_cmd_ready);

    // beat payload is its own byte address
    assign write_data_valid = beats_active;
    assign write_data = DATA_W'(beat_addr);
    assign write_data_last = (beats_left == CNT_W'(1));
    assign beat_fire = write_data_valid && write_data_ready;

    // sinks always accept once out of reset
    assign read_data_ready = sink_ready;
    assign write_sts_ready = sink_ready;

    // reads finish on the last beat, writes on their status
    assign complete = running && (run_cmd.is_write ?
                      (write_sts_valid && write_sts_ready) :
                      (read_data_valid && read_data_ready && read_data_last));
    assign finish = complete && (done_cnt + CNT_W'(1) == run_cmd.number_of_accesses);

    assign cycles = cycle_cnt;

    always_ff @(posedge net_clk) begin
        if (!net_aresetn) begin
            running <= 1'b0;
            beats_active <= 1'b0;
            done <= 1'b0;
            sink_ready <= 1'b0;
            issue_cnt <= '0;
            done_cnt <= '0;
            offset <= '0;
            cycle_cnt <= '0;
        end else begin
            sink_ready <= 1'b1;
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                beats_active <= 1'b0;
                issue_cnt <= '0;
                done_cnt <= '0;
                offset <= '0;
                cycle_cnt <= '0;
            end else if (running) begin
                cycle_cnt <= cycle_cnt + CYCLE_W'(1);
                if (cmd_fire) begin
                    issue_cnt <= issue_cnt + CNT_W'(1);
                    // back to the window start if the next chunk would overrun
                    if (next_end > {1'b0, run_cmd.memory_size}) begin
                        offset <= '0;
                    end else begin
                        offset <= next_offset;
                    end
                    beats_active <= run_cmd.is_write;
                end
                if (beat_fire && write_data_last) begin
                    beats_active <= 1'b0;
                end
                if (complete) begin
                    done_cnt <= done_cnt + CNT_W'(1);
                end
                if (finish) begin
                    running <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // write beat counter and address
    always_ff @(posedge net_clk) begin
        if (cmd_fire) begin
            beats_left <= run_cmd.chunk_length >> BEAT_SHIFT;
            beat_addr <= acc_addr;
        end else if (beat_fire) begin
            beats_left <= beats_left - CNT_W'(1);
            beat_addr <= beat_addr + ADDR_W'(BEAT_BYTES);
        end
    end

    // the latched command must describe whole beats
    chunk_whole_beats: assert property (
        @(posedge net_clk) disable iff (!net_aresetn)
        start |-> (run_cmd.chunk_length != '0) &&
                  (run_cmd.chunk_length[BEAT_SHIFT-1:0] == '0)
    );

    // run type comes from the latch and stays fixed, so no beats on a read run
    no_beats_on_read: assert property (
        @(posedge net_clk) disable iff (!net_aresetn)
        write_data_valid |-> run_cmd.is_write
    );

    read_data_known: assert property (
        @(posedge net_clk) disable iff (!net_aresetn)
        read_data_valid |-> !$isunknown(read_data)
    );

    write_sts_known: assert property (
        @(posedge net_clk) disable iff (!net_aresetn)
        write_sts_valid |-> !$isunknown(write_sts)
    );

endmodule

`default_nettype wire

// ==== source/bench_cmd_latch.sv ====
`timescale 1ns/1ns
`default_nettype none

module bench_cmd_latch (
    input  wire                                net_clk,
    input  wire                                net_aresetn,
    input  wire                                cmd_valid,
    output logic                               cmd_ready,
    input  wire bench_pkg::bench_cmd_t         cmd,
    input  wire [bench_pkg::DEST_W-1:0]        cmd_dest,
    output logic [bench_pkg::NUM_CHANNELS-1:0] start,
    output bench_pkg::bench_cmd_t              run_cmd,
    input  wire [bench_pkg::NUM_CHANNELS-1:0]  done,
    input  wire [bench_pkg::CYCLE_W-1:0]       cycles0,
    input  wire [bench_pkg::CYCLE_W-1:0]       cycles1,
    output logic                               busy,
    output logic                               result_valid,
    output logic [bench_pkg::CYCLE_W-1:0]      execution_cycles
);
    import bench_pkg::*;

    logic accept;
    logic busy_nxt;

    assign accept = cmd_valid && cmd_ready;

    // run flag: set on accept, dropped when a channel reports done
    always_comb begin
        busy_nxt = busy;
        if (accept) begin
            busy_nxt = 1'b1;
        end else if (|done) begin
            busy_nxt = 1'b0;
        end
    end

    always_ff @(posedge net_clk) begin
        if (!net_aresetn) begin
            busy <= 1'b0;
            cmd_ready <= 1'b0;
            start <= '0;
            result_valid <= 1'b0;
            execution_cycles <= '0;
        end else begin
            busy <= busy_nxt;
            // ready follows the run flag, no second command while one runs
            cmd_ready <= !busy_nxt;
            start <= '0;
            result_valid <= 1'b0;
            if (accept) begin
                // one-hot start for the addressed channel
                start <= NUM_CHANNELS'(1) << cmd_dest;
            end
            if (done[0]) begin
                execution_cycles <= cycles0;
                result_valid <= 1'b1;
            end
            if (done[1]) begin
                execution_cycles <= cycles1;
                result_valid <= 1'b1;
            end
        end
    end

    // command fields stay put for the whole run
    always_ff @(posedge net_clk) begin
        if (accept) begin
            run_cmd <= cmd;
        end
    end

    // no start while a run was already in progress
    start_after_idle_accept: assert property (
        @(posedge net_clk) disable iff (!net_aresetn)
        |start |-> !$past(busy)
    );

    // generators only finish runs that were started
    done_while_busy: assert property (
        @(posedge net_clk) disable iff (!net_aresetn)
        |done |-> busy
    );

endmodule

`default_nettype wire

// ==== source/bench_pkg.sv ====
`default_nettype none

package bench_pkg;

    // address and counter widths
    localparam int ADDR_W = 48;
    localparam int CNT_W = 32;
    localparam int CYCLE_W = 64;

    // memory data path
    localparam int DATA_W = 64;
    localparam int BEAT_BYTES = DATA_W / 8;
    localparam int BEAT_SHIFT = $clog2(BEAT_BYTES);
    localparam int STS_W = 8;

    // command word is length on top of a 64-bit address
    localparam int MEM_CMD_W = 96;
    localparam int MEM_ADDR_W = 64;
    localparam int MEM_LEN_W = MEM_CMD_W - MEM_ADDR_W;

    localparam int NUM_CHANNELS = 2;
    localparam int DEST_W = 1;

    // one benchmark request from the host
    typedef struct packed {
        logic [ADDR_W-1:0] base_addr;
        logic [ADDR_W-1:0] memory_size;
        logic [CNT_W-1:0]  number_of_accesses;
        logic [CNT_W-1:0]  chunk_length;
        logic [CNT_W-1:0]  stride_length;
        logic              is_write;
    } bench_cmd_t;

    // read or write command towards a memory channel
    typedef struct packed {
        logic [MEM_LEN_W-1:0]  length;
        logic [MEM_ADDR_W-1:0] addr;
    } mem_cmd_t;

endpackage

`default_nettype wire

// ==== source/bench_role.sv ====
`timescale 1ns/1ns
`default_nettype none

module bench_role (
    input  wire                            net_clk,
    input  wire                            net_aresetn,

    // host side
    input  wire                            cmd_valid,
    output logic                           cmd_ready,
    input  wire bench_pkg::bench_cmd_t     cmd,
    input  wire [bench_pkg::DEST_W-1:0]    cmd_dest,
    output logic                           busy,
    output logic                           result_valid,
    output logic [bench_pkg::CYCLE_W-1:0]  execution_cycles,

    // memory channel 0
    output logic                           mem0_read_cmd_valid,
    input  wire                            mem0_read_cmd_ready,
    output bench_pkg::mem_cmd_t            mem0_read_cmd,
    output logic                           mem0_write_cmd_valid,
    input  wire                            mem0_write_cmd_ready,
    output bench_pkg::mem_cmd_t            mem0_write_cmd,
    output logic                           mem0_write_data_valid,
    input  wire                            mem0_write_data_ready,
    output logic [bench_pkg::DATA_W-1:0]   mem0_write_data,
    output logic                           mem0_write_data_last,
    input  wire                            mem0_read_data_valid,
    output logic                           mem0_read_data_ready,
    input  wire [bench_pkg::DATA_W-1:0]    mem0_read_data,
    input  wire                            mem0_read_data_last,
    input  wire                            mem0_write_sts_valid,
    output logic                           mem0_write_sts_ready,
    input  wire [bench_pkg::STS_W-1:0]     mem0_write_sts,

    // memory channel 1
    output logic                           mem1_read_cmd_valid,
    input  wire                            mem1_read_cmd_ready,
    output bench_pkg::mem_cmd_t            mem1_read_cmd,
    output logic                           mem1_write_cmd_valid,
    input  wire                            mem1_write_cmd_ready,
    output bench_pkg::mem_cmd_t            mem1_write_cmd,
    output logic                           mem1_write_data_valid,
    input  wire                            mem1_write_data_ready,
    output logic [bench_pkg::DATA_W-1:0]   mem1_write_data,
    output logic                           mem1_write_data_last,
    input  wire                            mem1_read_data_valid,
    output logic                           mem1_read_data_ready,
    input  wire [bench_pkg::DATA_W-1:0]    mem1_read_data,
    input  wire                            mem1_read_data_last,
    input  wire                            mem1_write_sts_valid,
    output logic                           mem1_write_sts_ready,
    input  wire [bench_pkg::STS_W-1:0]     mem1_write_sts
);
    import bench_pkg::*;

    logic [NUM_CHANNELS-1:0] start;
    logic [NUM_CHANNELS-1:0] done;
    logic [CYCLE_W-1:0]      cycles0;
    logic [CYCLE_W-1:0]      cycles1;
    bench_cmd_t              run_cmd;

    bench_cmd_latch latch_i (
        .net_clk          (net_clk),
        .net_aresetn      (net_aresetn),
        .cmd_valid        (cmd_valid),
        .cmd_ready        (cmd_ready),
        .cmd              (cmd),
        .cmd_dest         (cmd_dest),
        .start            (start),
        .run_cmd          (run_cmd),
        .done             (done),
        .cycles0          (cycles0),
        .cycles1          (cycles1),
        .busy             (busy),
        .result_valid     (result_valid),
        .execution_cycles (execution_cycles)
    );

    // both channels share the latched command, start picks one
    access_generator gen0 (
        .net_clk          (net_clk),
        .net_aresetn      (net_aresetn),
        .start            (start[0]),
        .run_cmd          (run_cmd),
        .read_cmd_valid   (mem0_read_cmd_valid),
        .read_cmd_ready   (mem0_read_cmd_ready),
        .read_cmd         (mem0_read_cmd),
        .write_cmd_valid  (mem0_write_cmd_valid),
        .write_cmd_ready  (mem0_write_cmd_ready),
        .write_cmd        (mem0_write_cmd),
        .write_data_valid (mem0_write_data_valid),
        .write_data_ready (mem0_write_data_ready),
        .write_data       (mem0_write_data),
        .write_data_last  (mem0_write_data_last),
        .read_data_valid  (mem0_read_data_valid),
        .read_data_ready  (mem0_read_data_ready),
        .read_data        (mem0_read_data),
        .read_data_last   (mem0_read_data_last),
        .write_sts_valid  (mem0_write_sts_valid),
        .write_sts_ready  (mem0_write_sts_ready),
        .write_sts        (mem0_write_sts),
        .done             (done[0]),
        .cycles           (cycles0)
    );

    access_generator gen1 (
        .net_clk          (net_clk),
        .net_aresetn      (net_aresetn),
        .start            (start[1]),
        .run_cmd          (run_cmd),
        .read_cmd_valid   (mem1_read_cmd_valid),
        .read_cmd_ready   (mem1_read_cmd_ready),
        .read_cmd         (mem1_read_cmd),
        .write_cmd_valid  (mem1_write_cmd_valid),
        .write_cmd_ready  (mem1_write_cmd_ready),
        .write_cmd        (mem1_write_cmd),
        .write_data_valid (mem1_write_data_valid),
        .write_data_ready (mem1_write_data_ready),
        .write_data       (mem1_write_data),
        .write_data_last  (mem1_write_data_last),
        .read_data_valid  (mem1_read_data_valid),
        .read_data_ready  (mem1_read_data_ready),
        .read_data        (mem1_read_data),
        .read_data_last   (mem1_read_data_last),
        .write_sts_valid  (mem1_write_sts_valid),
        .write_sts_ready  (mem1_write_sts_ready),
        .write_sts        (mem1_write_sts),
        .done             (done[1]),
        .cycles           (cycles1)
    );

endmodule

`default_nettype wire

// ==== src.f ====
source/bench_pkg.sv
source/bench_cmd_latch.sv
source/access_generator.sv
source/bench_role.sv
tests/tb_clock.sv
tests/bench_role_tb.sv

// ==== tests/bench_role_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

// response side of one memory channel with random ready stalls
module mem_channel_model #(
    parameter logic [31:0] SEED = 32'hf7d1_5e52
) (
    input  wire                 net_clk,
    input  wire                 net_aresetn,
    input  wire                 read_cmd_valid,
    output logic                read_cmd_ready,
    input  wire bench_pkg::mem_cmd_t read_cmd,
    input  wire                 write_cmd_valid,
    output logic                write_cmd_ready,
    input  wire                 write_data_valid,
    output logic                write_data_ready,
    input  wire                 write_data_last,
    output logic                read_data_valid,
    input  wire                 read_data_ready,
    output logic [63:0]         read_data,
    output logic                read_data_last,
    output logic                write_sts_valid,
    input  wire                 write_sts_ready,
    output logic [7:0]          write_sts
);
    logic [31:0] rng;
    logic [31:0] rd_seq;
    int          rd_lens[$];
    int          rd_left;
    int          sts_pend;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    always @(posedge net_clk) begin
        if (!net_aresetn) begin
            rng = SEED;
            rd_seq = 32'h0;
            rd_left = 0;
            sts_pend = 0;
            rd_lens.delete();
            read_cmd_ready <= 1'b0;
            write_cmd_ready <= 1'b0;
            write_data_ready <= 1'b0;
            read_data_valid <= 1'b0;
            read_data <= 64'h0;
            read_data_last <= 1'b0;
            write_sts_valid <= 1'b0;
            write_sts <= 8'h0;
        end else begin
            rng = xorshift(rng);
            // roughly three cycles in four ready
            read_cmd_ready <= (rng[1:0] != 2'b00);
            write_cmd_ready <= (rng[3:2] != 2'b00);
            write_data_ready <= (rng[5:4] != 2'b00);
            if (read_cmd_valid && read_cmd_ready) begin
                rd_lens.push_back(int'(read_cmd.length >> 3));
            end
            if (write_data_valid && write_data_ready && write_data_last) begin
                sts_pend++;
            end
            // read beats, one command after the other
            if (!read_data_valid || read_data_ready) begin
                if (rd_left == 0 && rd_lens.size() > 0) begin
                    rd_left = rd_lens.pop_front();
                end
                if (rd_left > 0) begin
                    read_data_valid <= 1'b1;
                    read_data <= {32'h0, rd_seq};
                    read_data_last <= (rd_left == 1);
                    rd_left--;
                    rd_seq = rd_seq + 32'h1;
                end else begin
                    read_data_valid <= 1'b0;
                    read_data_last <= 1'b0;
                end
            end
            if (!write_sts_valid || write_sts_ready) begin
                if (sts_pend > 0) begin
                    write_sts_valid <= 1'b1;
                    sts_pend--;
                end else begin
                    write_sts_valid <= 1'b0;
                end
            end
        end
    end

endmodule

module bench_role_tb;
    import bench_pkg::*;

    localparam int TIMEOUT = 5000;

    logic                  net_clk;
    logic                  net_aresetn;
    logic                  cmd_valid;
    logic                  cmd_ready;
    bench_cmd_t            cmd;
    logic [DEST_W-1:0]     cmd_dest;
    logic                  busy;
    logic                  result_valid;
    logic [CYCLE_W-1:0]    execution_cycles;

    // per-channel streams, index is the channel
    logic [1:0]  rc_valid;
    logic [1:0]  rc_ready;
    logic [1:0]  wc_valid;
    logic [1:0]  wc_ready;
    logic [1:0]  wd_valid;
    logic [1:0]  wd_ready;
    logic [1:0]  wd_last;
    logic [1:0]  rd_valid;
    logic [1:0]  rd_ready;
    logic [1:0]  rd_last;
    logic [1:0]  ws_valid;
    logic [1:0]  ws_ready;
    mem_cmd_t    rc[2];
    mem_cmd_t    wc[2];
    logic [63:0] wd[2];
    logic [63:0] rd[2];
    logic [7:0]  ws[2];

    // expected accesses of the running command
    logic [63:0] exp_addr[$];
    logic [63:0] exp_len[$];
    int          act_ch;
    logic        act_write;
    logic [63:0] wb_addr[2];
    int          wb_left[2];
    int          result_count;
    int          fd;

    tb_clock clock_i (
        .net_clk     (net_clk),
        .net_aresetn (net_aresetn)
    );

    bench_role bench_role_i (
        .net_clk (net_clk), .net_aresetn (net_aresetn),
        .cmd_valid (cmd_valid), .cmd_ready (cmd_ready), .cmd (cmd), .cmd_dest (cmd_dest),
        .busy (busy), .result_valid (result_valid), .execution_cycles (execution_cycles),
        .mem0_read_cmd_valid (rc_valid[0]), .mem0_read_cmd_ready (rc_ready[0]),
        .mem0_read_cmd (rc[0]), .mem0_write_cmd_valid (wc_valid[0]),
        .mem0_write_cmd_ready (wc_ready[0]), .mem0_write_cmd (wc[0]),
        .mem0_write_data_valid (wd_valid[0]), .mem0_write_data_ready (wd_ready[0]),
        .mem0_write_data (wd[0]), .mem0_write_data_last (wd_last[0]),
        .mem0_read_data_valid (rd_valid[0]), .mem0_read_data_ready (rd_ready[0]),
        .mem0_read_data (rd[0]), .mem0_read_data_last (rd_last[0]),
        .mem0_write_sts_valid (ws_valid[0]), .mem0_write_sts_ready (ws_ready[0]),
        .mem0_write_sts (ws[0]),
        .mem1_read_cmd_valid (rc_valid[1]), .mem1_read_cmd_ready (rc_ready[1]),
        .mem1_read_cmd (rc[1]), .mem1_write_cmd_valid (wc_valid[1]),
        .mem1_write_cmd_ready (wc_ready[1]), .mem1_write_cmd (wc[1]),
        .mem1_write_data_valid (wd_valid[1]), .mem1_write_data_ready (wd_ready[1]),
        .mem1_write_data (wd[1]), .mem1_write_data_last (wd_last[1]),
        .mem1_read_data_valid (rd_valid[1]), .mem1_read_data_ready (rd_ready[1]),
        .mem1_read_data (rd[1]), .mem1_read_data_last (rd_last[1]),
        .mem1_write_sts_valid (ws_valid[1]), .mem1_write_sts_ready (ws_ready[1]),
        .mem1_write_sts (ws[1])
    );

    for (genvar g = 0; g < 2; g++) begin : models
        mem_channel_model #(.SEED(32'hf7d1_5e52)) model_i (
            .net_clk (net_clk), .net_aresetn (net_aresetn),
            .read_cmd_valid (rc_valid[g]), .read_cmd_ready (rc_ready[g]),
            .read_cmd (rc[g]), .write_cmd_valid (wc_valid[g]),
            .write_cmd_ready (wc_ready[g]), .write_data_valid (wd_valid[g]),
            .write_data_ready (wd_ready[g]), .write_data_last (wd_last[g]),
            .read_data_valid (rd_valid[g]), .read_data_ready (rd_ready[g]),
            .read_data (rd[g]), .read_data_last (rd_last[g]),
            .write_sts_valid (ws_valid[g]), .write_sts_ready (ws_ready[g]),
            .write_sts (ws[g])
        );
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch %s got 0x%h expected 0x%h", name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic take_command(input int ch, input logic is_wr, input mem_cmd_t c);
        logic [63:0] addr;
        logic [63:0] len;
        if (ch != act_ch || is_wr != act_write) begin
            fail_run($sformatf("unexpected command on channel %0d", ch));
        end
        if (exp_addr.size() == 0) begin
            fail_run("more access commands than the trace lists");
        end
        if (wb_left[ch] != 0) begin
            fail_run("command issued before the previous write beats were sent");
        end
        addr = exp_addr.pop_front();
        len = exp_len.pop_front();
        check_value("mem_cmd.addr", c.addr, addr);
        check_value("mem_cmd.length", 64'(c.length), len);
        if (is_wr) begin
            wb_addr[ch] = addr;
            wb_left[ch] = int'(len >> 3);
        end
    endtask

    task automatic take_beat(input int ch, input logic [63:0] data, input logic last);
        if (wb_left[ch] == 0) begin
            fail_run("write beat without a pending write command");
        end
        check_value("write_data", data, wb_addr[ch]);
        check_value("write_data_last", 64'(last), 64'(wb_left[ch] == 1));
        wb_addr[ch] = wb_addr[ch] + 64'h8;
        wb_left[ch]--;
    endtask

    // stream monitor
    always @(posedge net_clk) begin
        if (net_aresetn) begin
            for (int ch = 0; ch < 2; ch++) begin
                if (rc_valid[ch] && rc_ready[ch]) begin
                    take_command(ch, 1'b0, rc[ch]);
                end
                if (wc_valid[ch] && wc_ready[ch]) begin
                    take_command(ch, 1'b1, wc[ch]);
                end
                if (wd_valid[ch] && wd_ready[ch]) begin
                    take_beat(ch, wd[ch], wd_last[ch]);
                end
                if (!busy && (rc_valid[ch] || wc_valid[ch] || wd_valid[ch])) begin
                    fail_run("memory stream valid while the role is idle");
                end
            end
            // sinks accept at all times once the role is up
            if (cmd_ready || busy) begin
                check_value("read_data_ready", 64'(rd_ready), 64'h3);
                check_value("write_sts_ready", 64'(ws_ready), 64'h3);
            end
            if (busy && cmd_ready) begin
                fail_run("cmd_ready high while busy");
            end
            if (result_valid) begin
                result_count++;
            end
        end
    end

    // next line of the trace that is not a comment, 0 at end of file
    function automatic int next_line(output string line);
        byte c;
        while ($fgets(line, fd) != 0) begin
            c = line.getc(0);
            if (c != "#" && c != "\n" && line.len() > 0) begin
                return 1;
            end
        end
        return 0;
    endfunction

    task automatic run_trace_command(input string line);
        logic [63:0] f[8];
        string       al;
        logic [63:0] a;
        logic [63:0] l;
        int          n;
        int          measured;
        if ($sscanf(line, "C %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                    f[4], f[5], f[6], f[7]) != 8) begin
            fail_run("malformed command line in the trace");
        end
        for (int i = 0; i < int'(f[4]); i++) begin
            if (next_line(al) == 0 || $sscanf(al, "A %h %h", a, l) != 2) begin
                fail_run("trace ended before all access lines were read");
            end
            exp_addr.push_back(a);
            exp_len.push_back(l);
        end
        act_ch = int'(f[0]);
        act_write = f[1][0];
        @(posedge net_clk);
        cmd_valid <= 1'b1;
        cmd_dest <= f[0][DEST_W-1:0];
        cmd.is_write <= f[1][0];
        cmd.base_addr <= f[2][ADDR_W-1:0];
        cmd.memory_size <= f[3][ADDR_W-1:0];
        cmd.number_of_accesses <= f[4][CNT_W-1:0];
        cmd.chunk_length <= f[5][CNT_W-1:0];
        cmd.stride_length <= f[6][CNT_W-1:0];
        n = 0;
        @(posedge net_clk);
        while (!(cmd_valid && cmd_ready)) begin
            n++;
            if (n > TIMEOUT) begin
                fail_run("timeout waiting for the command to be accepted");
            end
            @(posedge net_clk);
        end
        cmd_valid <= 1'b0;
        measured = 0;
        @(posedge net_clk);
        measured++;
        while (!result_valid) begin
            if (measured > TIMEOUT) begin
                fail_run("timeout waiting for result_valid");
            end
            @(posedge net_clk);
            measured++;
        end
        if (execution_cycles < f[7] || execution_cycles < 64'(f[4])) begin
            fail_run($sformatf("execution_cycles 0x%h below the expected floor",
                               execution_cycles));
        end
        if (execution_cycles > 64'(measured)) begin
            fail_run("execution_cycles longer than the measured run");
        end
        check_value("pending access count", 64'(exp_addr.size()), 64'h0);
        check_value("pending write beats", 64'(wb_left[act_ch]), 64'h0);
        @(posedge net_clk);
        check_value("busy", 64'(busy), 64'h0);
        check_value("result_valid", 64'(result_valid), 64'h0);
    endtask

    initial begin
        string line;
        int    runs;
        int    n;
        cmd_valid = 1'b0;
        cmd = '0;
        cmd_dest = '0;
        act_ch = -1;
        act_write = 1'b0;
        wb_left[0] = 0;
        wb_left[1] = 0;
        result_count = 0;
        runs = 0;
        fd = $fopen("tests/bench_trace.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open tests/bench_trace.txt");
        end
        n = 0;
        @(posedge net_clk);
        while (!(net_aresetn && cmd_ready)) begin
            n++;
            if (n > 100) begin
                fail_run("timeout waiting for cmd_ready after reset");
            end
            @(posedge net_clk);
        end
        check_value("busy", 64'(busy), 64'h0);
        check_value("result_valid", 64'(result_valid), 64'h0);
        while (next_line(line) != 0) begin
            run_trace_command(line);
            runs++;
        end
        $fclose(fd);
        if (result_count == runs && runs > 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("%0d result pulses for %0d commands", result_count, runs);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== tests/bench_trace.txt ====
# C dest is_write base_addr memory_size accesses chunk stride cycle_floor (hex)
# A addr length (hex), one line per access of the command above
C 0 0 1000 100 6 40 40 6
A 1000 40
A 1040 40
A 1080 40
A 10c0 40
A 1000 40
A 1040 40
C 1 1 2000 80 4 20 30 4
A 2000 20
A 2030 20
A 2060 20
A 2000 20
C 1 0 300 1000 2 8 8 2
A 300 8
A 308 8
C 0 1 4000 40 3 10 10 3
A 4000 10
A 4010 10
A 4020 10

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic net_clk,
    output logic net_aresetn
);
    // 20 ns period
    initial begin
        net_clk = 1'b0;
        forever #10 net_clk = ~net_clk;
    end

    // reset held low for two rising edges
    initial begin
        net_aresetn = 1'b0;
        repeat (2) @(posedge net_clk);
        net_aresetn <= 1'b1;
    end

endmodule

`default_nettype wire
